/* msx_ram_pkg.sv */
/*
 * MSX RAM subsystem shared definitions
 * Widths of the expansion bus and the PSRAM port, plus the state
 * encodings of the bus bridge and the PSRAM arbiter.
 */

`default_nettype none

package msx_ram_pkg;

	// --------------------
	// bus and PSRAM widths
	// --------------------

	// full 64 KB bus address and the byte that travels on the bus
	typedef logic [15:0] bus_addr_t;
	typedef logic [7:0] bus_data_t;
	// page number is the top two bits of the bus address
	typedef logic [1:0] page_t;
	// 4 MB byte addressed PSRAM
	typedef logic [21:0] psram_addr_t;
	// offset inside a 16 KB page
	typedef logic [13:0] page_offset_t;
	// upper PSRAM bits that pick one 16 KB region
	typedef logic [7:0] region_t;

	// --------------------
	// state machines
	// --------------------

	// one bus access walks idle, request, wait for data and reply
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_REQUEST,
		BR_WAIT_DATA,
		BR_REPLY
	} bridge_state_t;

	// the arbiter remembers which bridge owns the PSRAM port
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUSY_A,
		ARB_BUSY_B
	} arb_state_t;

endpackage

`default_nettype wire

/* msx_ram_bridge.sv */
/*
 * MSX bus RAM bridge
 * Decodes one 16 KB page of the bus space and turns the level style
 * memory read and write strobes into single PSRAM requests.
 * A read returns its byte to the bus as a one cycle reply.
 */

`timescale 1ns/100ps
`default_nettype none

module msx_ram_bridge import msx_ram_pkg::*; #(
	parameter page_t PAGE = 2'd2,
	parameter region_t REGION = 8'd0
) (
	input wire logic clk,
	input wire logic n_reset,
	// expansion bus side
	input wire bus_addr_t bus_address,
	input wire bus_data_t bus_write_data,
	input wire logic bus_memory_read,
	input wire logic bus_memory_write,
	// request towards the arbiter
	output logic req_rd,
	output logic req_wr,
	output psram_addr_t req_address,
	output bus_data_t req_wdata,
	input wire logic req_busy,
	// read completion from the arbiter
	input wire bus_data_t rsp_data,
	input wire logic rsp_en,
	// reply towards the bus merge
	output logic reply_ready,
	output bus_data_t reply_data
);

	logic ff_memory_read;
	logic ff_memory_write;
	logic read_rise;
	logic write_rise;
	logic dec;
	logic read_live;
	page_offset_t offset;
	bridge_state_t state;

	// --------------------
	// strobe edge detect
	// --------------------

	// registered copies of the strobes, compared with the live ones
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_memory_read <= 1'b0;
			ff_memory_write <= 1'b0;
		end else begin
			ff_memory_read <= bus_memory_read;
			ff_memory_write <= bus_memory_write;
		end
	end

	// this bridge only answers for its own page
	assign dec = (bus_address[15:14] == PAGE);
	assign offset = bus_address[13:0];

	// only an edge seen inside the page starts an access
	assign read_rise = bus_memory_read & ~ff_memory_read & dec;
	assign write_rise = bus_memory_write & ~ff_memory_write & dec;

	// a read stays worth finishing while the master still asks for it here
	assign read_live = bus_memory_read & dec;

	// --------------------
	// access state machine
	// --------------------

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state <= BR_IDLE;
			req_rd <= 1'b0;
			req_wr <= 1'b0;
			req_address <= '0;
			req_wdata <= '0;
			reply_ready <= 1'b0;
			reply_data <= '0;
		end else begin
			case (state)
				BR_IDLE: begin
					// the PSRAM address is built from the bus offset, never from our output
					if (read_rise) begin
						req_rd <= 1'b1;
						req_address <= {REGION, offset};
						state <= BR_REQUEST;
					end else if (write_rise) begin
						req_wr <= 1'b1;
						req_address <= {REGION, offset};
						req_wdata <= bus_write_data;
						state <= BR_REQUEST;
					end
				end
				BR_REQUEST: begin
					// request and data hold still until a cycle without busy
					if (!req_busy) begin
						req_rd <= 1'b0;
						req_wr <= 1'b0;
						req_address <= '0;
						req_wdata <= '0;
						// a write is done once accepted, a read now waits for its byte
						state <= (req_rd && read_live) ? BR_WAIT_DATA : BR_IDLE;
					end else if (req_rd && !read_live) begin
						// master gave up before acceptance, so the read is dropped
						req_rd <= 1'b0;
						req_address <= '0;
						state <= BR_IDLE;
					end
				end
				BR_WAIT_DATA: begin
					if (!read_live) begin
						// a late completion is simply ignored in idle
						state <= BR_IDLE;
					end else if (rsp_en) begin
						reply_ready <= 1'b1;
						reply_data <= rsp_data;
						state <= BR_REPLY;
					end
				end
				BR_REPLY: begin
					// reply is shown for exactly one cycle and then cleared
					// so that the OR merge in the arbiter sees zero again
					reply_ready <= 1'b0;
					reply_data <= '0;
					state <= BR_IDLE;
				end
				default: begin
					state <= BR_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* msx_psram_arbiter.sv */
/*
 * PSRAM arbiter for two bus RAM bridges
 * Hands the single PSRAM port to bridge A or B with A first, keeps the
 * owner until the PSRAM drops busy and routes read data to that owner.
 * Also merges both bridge replies into the one bus reply.
 */

`timescale 1ns/100ps
`default_nettype none

module msx_psram_arbiter import msx_ram_pkg::*; (
	input wire logic clk,
	input wire logic n_reset,
	// bridge A request and completion
	input wire logic a_rd,
	input wire logic a_wr,
	input wire psram_addr_t a_address,
	input wire bus_data_t a_wdata,
	output logic a_busy,
	output bus_data_t a_rsp_data,
	output logic a_rsp_en,
	// bridge B request and completion
	input wire logic b_rd,
	input wire logic b_wr,
	input wire psram_addr_t b_address,
	input wire bus_data_t b_wdata,
	output logic b_busy,
	output bus_data_t b_rsp_data,
	output logic b_rsp_en,
	// bridge replies and the merged bus reply
	input wire logic a_reply_ready,
	input wire bus_data_t a_reply_data,
	input wire logic b_reply_ready,
	input wire bus_data_t b_reply_data,
	output logic bus_read_ready,
	output bus_data_t bus_read_data,
	// shared PSRAM port
	output logic rd,
	output logic wr,
	output psram_addr_t address,
	output bus_data_t wdata,
	input wire logic busy,
	input wire bus_data_t rdata,
	input wire logic rdata_en
);

	arb_state_t state;
	logic sel_a;
	logic sel_b;

	// --------------------
	// grant select
	// --------------------

	// a held grant wins, otherwise bridge A has fixed priority
	always_comb begin
		sel_a = 1'b0;
		sel_b = 1'b0;
		case (state)
			ARB_BUSY_A: sel_a = 1'b1;
			ARB_BUSY_B: sel_b = 1'b1;
			default: begin
				if (a_rd || a_wr) begin
					sel_a = 1'b1;
				end else if (b_rd || b_wr) begin
					sel_b = 1'b1;
				end
			end
		endcase
	end

	// port follows the selected bridge with no added cycle
	always_comb begin
		if (sel_a) begin
			rd = a_rd;
			wr = a_wr;
			address = a_address;
			wdata = a_wdata;
		end else if (sel_b) begin
			rd = b_rd;
			wr = b_wr;
			address = b_address;
			wdata = b_wdata;
		end else begin
			rd = 1'b0;
			wr = 1'b0;
			address = '0;
			wdata = '0;
		end
	end

	// --------------------
	// owner tracking
	// --------------------

	// owner is latched whenever the PSRAM accepts, and released when busy ends
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state <= ARB_IDLE;
		end else if (!busy) begin
			if ((rd || wr) && sel_a) begin
				state <= ARB_BUSY_A;
			end else if ((rd || wr) && sel_b) begin
				state <= ARB_BUSY_B;
			end else begin
				state <= ARB_IDLE;
			end
		end
	end

	// the bridge without the grant must keep waiting
	assign a_busy = busy | sel_b;
	assign b_busy = busy | sel_a;

	// completion goes only to the bridge that issued the read
	assign a_rsp_en = rdata_en & (state == ARB_BUSY_A);
	assign b_rsp_en = rdata_en & (state == ARB_BUSY_B);
	assign a_rsp_data = (state == ARB_BUSY_A) ? rdata : '0;
	assign b_rsp_data = (state == ARB_BUSY_B) ? rdata : '0;

	// an idle bridge drives zero, so OR is enough for the bus reply
	assign bus_read_ready = a_reply_ready | b_reply_ready;
	assign bus_read_data = a_reply_data | b_reply_data;

endmodule

`default_nettype wire

/* msx_ram_top.sv */
/*
 * MSX RAM subsystem top level
 * Two page bridges share one PSRAM port through the arbiter.
 */

`timescale 1ns/100ps
`default_nettype none

module msx_ram_top import msx_ram_pkg::*; #(
	parameter page_t PAGE_A = 2'd2,
	parameter region_t REGION_A = 8'd0,
	parameter page_t PAGE_B = 2'd1,
	parameter region_t REGION_B = 8'd1
) (
	input wire logic clk,
	input wire logic n_reset,
	// expansion bus
	input wire bus_addr_t bus_address,
	input wire bus_data_t bus_write_data,
	input wire logic bus_memory_read,
	input wire logic bus_memory_write,
	output logic bus_read_ready,
	output bus_data_t bus_read_data,
	// external PSRAM
	output logic rd,
	output logic wr,
	output psram_addr_t address,
	output bus_data_t wdata,
	input wire logic busy,
	input wire bus_data_t rdata,
	input wire logic rdata_en
);

	// bridge A links
	logic a_rd;
	logic a_wr;
	psram_addr_t a_address;
	bus_data_t a_wdata;
	logic a_busy;
	bus_data_t a_rsp_data;
	logic a_rsp_en;
	logic a_reply_ready;
	bus_data_t a_reply_data;

	// bridge B links
	logic b_rd;
	logic b_wr;
	psram_addr_t b_address;
	bus_data_t b_wdata;
	logic b_busy;
	bus_data_t b_rsp_data;
	logic b_rsp_en;
	logic b_reply_ready;
	bus_data_t b_reply_data;

	// page A bridge, page 2 by default
	msx_ram_bridge #(
		.PAGE(PAGE_A),
		.REGION(REGION_A)
	) u_bridge_a (
		.clk(clk),
		.n_reset(n_reset),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_memory_read(bus_memory_read),
		.bus_memory_write(bus_memory_write),
		.req_rd(a_rd),
		.req_wr(a_wr),
		.req_address(a_address),
		.req_wdata(a_wdata),
		.req_busy(a_busy),
		.rsp_data(a_rsp_data),
		.rsp_en(a_rsp_en),
		.reply_ready(a_reply_ready),
		.reply_data(a_reply_data)
	);

	// page B bridge, in its own PSRAM region so the pages never alias
	msx_ram_bridge #(
		.PAGE(PAGE_B),
		.REGION(REGION_B)
	) u_bridge_b (
		.clk(clk),
		.n_reset(n_reset),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_memory_read(bus_memory_read),
		.bus_memory_write(bus_memory_write),
		.req_rd(b_rd),
		.req_wr(b_wr),
		.req_address(b_address),
		.req_wdata(b_wdata),
		.req_busy(b_busy),
		.rsp_data(b_rsp_data),
		.rsp_en(b_rsp_en),
		.reply_ready(b_reply_ready),
		.reply_data(b_reply_data)
	);

	msx_psram_arbiter u_arbiter (
		.clk(clk),
		.n_reset(n_reset),
		.a_rd(a_rd),
		.a_wr(a_wr),
		.a_address(a_address),
		.a_wdata(a_wdata),
		.a_busy(a_busy),
		.a_rsp_data(a_rsp_data),
		.a_rsp_en(a_rsp_en),
		.b_rd(b_rd),
		.b_wr(b_wr),
		.b_address(b_address),
		.b_wdata(b_wdata),
		.b_busy(b_busy),
		.b_rsp_data(b_rsp_data),
		.b_rsp_en(b_rsp_en),
		.a_reply_ready(a_reply_ready),
		.a_reply_data(a_reply_data),
		.b_reply_ready(b_reply_ready),
		.b_reply_data(b_reply_data),
		.bus_read_ready(bus_read_ready),
		.bus_read_data(bus_read_data),
		.rd(rd),
		.wr(wr),
		.address(address),
		.wdata(wdata),
		.busy(busy),
		.rdata(rdata),
		.rdata_en(rdata_en)
	);

endmodule

`default_nettype wire

/* tb_psram_model.sv */
/*
 * behavioral PSRAM for the testbench
 * Sparse 4 MB byte store with a fixed busy phase after each accepted
 * request and a one cycle rdata_en pulse at the end of a read.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_psram_model import msx_ram_pkg::*; #(
	parameter int LATENCY = 4
) (
	input wire logic clk,
	input wire logic n_reset,
	input wire logic rd,
	input wire logic wr,
	input wire psram_addr_t address,
	input wire bus_data_t wdata,
	output logic busy,
	output bus_data_t rdata,
	output logic rdata_en
);

	// only bytes that were written exist, the rest read as zero
	bus_data_t mem [psram_addr_t];
	int count;
	logic pending_rd;
	bus_data_t read_byte;

	always @(posedge clk) begin
		if (!n_reset) begin
			busy <= 1'b0;
			rdata <= '0;
			rdata_en <= 1'b0;
			count <= 0;
			pending_rd <= 1'b0;
			read_byte <= '0;
		end else begin
			rdata_en <= 1'b0;
			if (!busy && (rd || wr)) begin
				// request accepted, busy covers the whole access
				busy <= 1'b1;
				count <= LATENCY;
				pending_rd <= rd;
				if (wr) begin
					mem[address] = wdata;
				end
				read_byte <= mem.exists(address) ? mem[address] : 8'h00;
			end else if (busy) begin
				// the last busy cycle hands over the read byte
				if (count == 1) begin
					busy <= 1'b0;
					rdata_en <= pending_rd;
					rdata <= read_byte;
					pending_rd <= 1'b0;
				end
				count <= count - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* msx_ram_sva.sv */
/*
 * protocol assertions for the MSX RAM top level
 * Watches the PSRAM port and the merged bus reply.
 */

`timescale 1ns/100ps
`default_nettype none

module msx_ram_sva import msx_ram_pkg::*; (
	input wire logic clk,
	input wire logic n_reset,
	input wire logic rd,
	input wire logic wr,
	input wire psram_addr_t address,
	input wire logic busy,
	input wire logic bus_read_ready
);

	// number of failed assertions, read by the testbench at the end
	int assert_failures = 0;

	// the PSRAM port carries one kind of request at a time
	assert property (@(posedge clk) disable iff (!n_reset) !(rd && wr))
		else begin
			$error("rd and wr are high in the same cycle");
			assert_failures++;
		end

	// a waiting request keeps its address until accepted or dropped
	assert property (@(posedge clk) disable iff (!n_reset)
		(rd || wr) && busy |=> $stable(address) || !(rd || wr))
		else begin
			$error("PSRAM address changed while the request waited under busy");
			assert_failures++;
		end

	// the bus reply is a single cycle pulse
	assert property (@(posedge clk) disable iff (!n_reset)
		bus_read_ready |=> !bus_read_ready)
		else begin
			$error("bus_read_ready stayed high for more than one cycle");
			assert_failures++;
		end

endmodule

bind msx_ram_top msx_ram_sva u_msx_ram_sva (
	.clk(clk),
	.n_reset(n_reset),
	.rd(rd),
	.wr(wr),
	.address(address),
	.busy(busy),
	.bus_read_ready(bus_read_ready)
);

`default_nettype wire

/* tb_msx_ram.sv */
/*
 * testbench for the MSX RAM subsystem
 * Drives bus reads and writes into pages 1 and 2, checks unmapped pages
 * stay silent, and compares every read reply with a bus space reference.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_msx_ram import msx_ram_pkg::*; ();

	localparam int PSRAM_LATENCY = 4;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_OPS = 200;
	localparam int DIRECTED_OPS = 8;
	localparam int NUM_OPS = DIRECTED_OPS + RANDOM_OPS;
	localparam int TIMEOUT_CYCLES = NUM_OPS * (PSRAM_LATENCY + 12) + RESET_CYCLES;
	// an idle PSRAM accepts a write two cycles after the strobe rises, and the strobe
	// ends while the PSRAM is still busy so that a following read waits under busy
	localparam int WRITE_HOLD = PSRAM_LATENCY - 1;
	// quiet cycles before a write, enough for an earlier write to leave busy
	localparam int WRITE_GAP = 3;
	// longest wait for a read reply, including a read queued behind a write
	localparam int READ_LIMIT = PSRAM_LATENCY + 8;

	logic clk;
	logic n_reset;
	bus_addr_t bus_address;
	bus_data_t bus_write_data;
	logic bus_memory_read;
	logic bus_memory_write;
	logic bus_read_ready;
	bus_data_t bus_read_data;
	logic rd;
	logic wr;
	psram_addr_t address;
	bus_data_t wdata;
	logic busy;
	bus_data_t rdata;
	logic rdata_en;

	bus_data_t ref_mem [0:65535];
	bus_data_t expected_data;
	logic read_pending;
	int psram_accepts = 0;
	int cycle_count = 0;
	int error_count = 0;
	int mismatch_count = 0;
	logic [31:0] lcg_state = 32'ha875_811b;

	msx_ram_top u_msx_ram_top (
		.clk(clk),
		.n_reset(n_reset),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_memory_read(bus_memory_read),
		.bus_memory_write(bus_memory_write),
		.bus_read_ready(bus_read_ready),
		.bus_read_data(bus_read_data),
		.rd(rd),
		.wr(wr),
		.address(address),
		.wdata(wdata),
		.busy(busy),
		.rdata(rdata),
		.rdata_en(rdata_en)
	);

	tb_psram_model #(
		.LATENCY(PSRAM_LATENCY)
	) u_psram_model (
		.clk(clk),
		.n_reset(n_reset),
		.rd(rd),
		.wr(wr),
		.address(address),
		.wdata(wdata),
		.busy(busy),
		.rdata(rdata),
		.rdata_en(rdata_en)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// reference and helpers
	// --------------------

	// only pages 1 and 2 are backed by RAM
	function automatic logic is_mapped(input bus_addr_t addr);
		return (addr[15:14] == 2'd1) || (addr[15:14] == 2'd2);
	endfunction

	// last byte written at this bus address, zero if never written
	function automatic bus_data_t expected_read(input bus_addr_t addr);
		return is_mapped(addr) ? ref_mem[addr] : 8'h00;
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			$display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want);
			mismatch_count++;
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		error_count++;
	endtask

	// --------------------
	// bus master tasks
	// --------------------

	task automatic write_access(input bus_addr_t addr, input bus_data_t data);
		repeat (WRITE_GAP) @(posedge clk);
		bus_address <= addr;
		bus_write_data <= data;
		bus_memory_write <= 1'b1;
		if (is_mapped(addr)) begin
			ref_mem[addr] = data;
		end
		repeat (WRITE_HOLD) @(posedge clk);
		bus_memory_write <= 1'b0;
	endtask

	task automatic read_access(input bus_addr_t addr);
		int waited;
		logic seen;
		int accepts_before;
		waited = 0;
		seen = 1'b0;
		accepts_before = psram_accepts;
		@(posedge clk);
		bus_address <= addr;
		bus_memory_read <= 1'b1;
		expected_data <= expected_read(addr);
		read_pending <= is_mapped(addr);
		while (!seen && waited < READ_LIMIT) begin
			@(posedge clk);
			waited++;
			if (bus_read_ready) begin
				seen = 1'b1;
			end
		end
		bus_memory_read <= 1'b0;
		read_pending <= 1'b0;
		@(posedge clk);
		if (is_mapped(addr)) begin
			assert (seen) else report_failure($sformatf("no read reply for address 0x%0h", addr));
		end else begin
			assert (psram_accepts == accepts_before)
				else report_failure($sformatf("PSRAM got a request for unmapped 0x%0h", addr));
		end
	endtask

	// --------------------
	// monitors
	// --------------------

	// every bus reply must belong to a pending read and carry the reference byte
	always @(posedge clk) begin
		if (n_reset && bus_read_ready) begin
			assert (read_pending) else report_failure("bus reply arrived without a pending read");
			expect_equal("bus_read_data", bus_read_data, expected_data);
		end
	end

	always @(posedge clk) begin
		if (n_reset && (rd || wr) && !busy) begin
			psram_accepts <= psram_accepts + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	// --------------------
	// stimulus
	// --------------------

	initial begin
		logic [31:0] r;
		bus_addr_t addr;
		int i;
		for (i = 0; i < 65536; i++) begin
			ref_mem[i] = 8'h00;
		end
		n_reset <= 1'b0;
		bus_address <= '0;
		bus_write_data <= '0;
		bus_memory_read <= 1'b0;
		bus_memory_write <= 1'b0;
		expected_data <= '0;
		read_pending <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		n_reset <= 1'b1;

		// quiet port and bus right after reset
		repeat (4) begin
			@(posedge clk);
			expect_equal("rd", rd, 0);
			expect_equal("wr", wr, 0);
			expect_equal("address", address, 0);
			expect_equal("bus_read_ready", bus_read_ready, 0);
			expect_equal("bus_read_data", bus_read_data, 0);
		end

		// page 2 then page 1 at the same offset, which must not alias
		write_access(16'h8123, 8'h5a);
		read_access(16'h8123);
		write_access(16'h4123, 8'ha5);
		read_access(16'h4123);
		read_access(16'h8123);
		// pages 0 and 3 have no RAM behind them
		read_access(16'h0123);
		read_access(16'hc123);

		// random mix over a small window so reads often hit earlier writes
		for (i = 0; i < RANDOM_OPS; i++) begin
			r = lcg_next();
			addr = {(r[30] ? 2'd2 : 2'd1), 8'h00, r[29:24]};
			if (r[31]) begin
				write_access(addr, r[23:16]);
			end else begin
				read_access(addr);
			end
		end

		repeat (4) @(posedge clk);
		error_count += u_msx_ram_top.u_msx_ram_sva.assert_failures;
		$display("errors: %0d, value mismatches: %0d", error_count, mismatch_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
msx_ram_pkg.sv
msx_ram_bridge.sv
msx_psram_arbiter.sv
msx_ram_top.sv
tb_psram_model.sv
msx_ram_sva.sv
tb_msx_ram.sv

/* Bender.yml */
package:
  name: msx_ram

sources:
  - msx_ram_pkg.sv
  - msx_ram_bridge.sv
  - msx_psram_arbiter.sv
  - msx_ram_top.sv
  - target: simulation
    files:
      - tb_psram_model.sv
      - msx_ram_sva.sv
      - tb_msx_ram.sv
